/* controlUnit.f */
+incdir+include
source/cuPkg.sv
source/stateSequencer.sv
source/instrDecoder.sv
source/condEvaluator.sv
source/controlRom.sv
source/controlUnit.sv
verif/cuModel.sv
verif/tbControlUnit.sv

/* include/cu_consts.svh */
`ifndef CU_CONSTS_SVH
`define CU_CONSTS_SVH

// Sequencer state codes
`define STATE_W         7
`define ST_RESET        7'd0
`define ST_FETCH_ADDR   7'd1
`define ST_FETCH_INC    7'd2
`define ST_FETCH_WAIT   7'd3
`define ST_DECODE       7'd4
`define ST_DP_SHIFT     7'd5
`define ST_DP_IMM       7'd6
`define ST_BR_TARGET    7'd8
`define ST_BR_COMMIT    7'd9
`define ST_BR_LINK      7'd10

// Instruction word fields
`define COND_W          4
`define CLASS_W         3
`define FLAGS_W         4

// Instruction classes, bits 27 to 25
`define CLASS_DP_SHIFT  3'b000
`define CLASS_DP_IMM    3'b001
`define CLASS_BRANCH    3'b101

// Condition field encodings
`define COND_EQ         4'b0000
`define COND_NE         4'b0001
`define COND_CS         4'b0010
`define COND_CC         4'b0011
`define COND_MI         4'b0100
`define COND_PL         4'b0101
`define COND_VS         4'b0110
`define COND_VC         4'b0111
`define COND_HI         4'b1000
`define COND_LS         4'b1001
`define COND_GE         4'b1010
`define COND_LT         4'b1011
`define COND_GT         4'b1100
`define COND_LE         4'b1101
`define COND_AL         4'b1110

// Datapath control widths
`define ALUOP_W         5
`define MUXC_W          3
`define SHIFT_T_W       3

`endif

/* run.sh */
#!/bin/sh
# Builds the controlUnit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/10ps -f controlUnit.f \
	--top-module tbControlUnit -o simControlUnit
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simControlUnit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TEST OK" sim.log; then
	echo "Simulation log has no result line"
	exit 1
fi
exit 0

/* source/condEvaluator.sv */
`timescale 1ns/10ps
`include "cu_consts.svh"

module condEvaluator import cuPkg::*;
(
	input irWord_t ir,
	input logic [`FLAGS_W-1:0] flags,
	output logic condPass
);

	logic n;
	logic z;
	logic c;
	logic v;

	// Flag register order is N Z C V
	assign {n, z, c, v} = flags;

	always_comb
	begin
		case (ir.dp.cond)
			`COND_EQ: condPass = z;
			`COND_NE: condPass = !z;
			`COND_CS: condPass = c;
			`COND_CC: condPass = !c;
			`COND_MI: condPass = n;
			`COND_PL: condPass = !n;
			`COND_VS: condPass = v;
			`COND_VC: condPass = !v;
			// Unsigned higher and lower or same
			`COND_HI: condPass = c && !z;
			`COND_LS: condPass = !c || z;
			// Signed compares
			`COND_GE: condPass = (n == v);
			`COND_LT: condPass = (n != v);
			`COND_GT: condPass = !z && (n == v);
			`COND_LE: condPass = z || (n != v);
			`COND_AL: condPass = 1'b1;
			// Reserved code never executes
			default: condPass = 1'b0;
		endcase
	end

endmodule

/* source/controlRom.sv */
`timescale 1ns/10ps
`include "cu_consts.svh"

module controlRom
(
	input logic [`STATE_W-1:0] state,
	output logic regFileLoad,
	output logic irLoad,
	output logic marLoad,
	output logic memRead,
	output logic memValid,
	output logic flagLoad,
	output logic [1:0] muxA,
	output logic [1:0] muxB,
	output logic [`MUXC_W-1:0] muxC,
	output logic muxD,
	output logic [1:0] muxF,
	output logic muxH,
	output logic [1:0] muxJ,
	output logic shiftEnable,
	output logic [`SHIFT_T_W-1:0] shiftType,
	output logic offsetShift,
	output logic [`ALUOP_W-1:0] aluOp
);

	always_comb
	begin
		// Idle word by default
		regFileLoad = 1'b0;
		irLoad = 1'b0;
		marLoad = 1'b0;
		memRead = 1'b0;
		memValid = 1'b0;
		flagLoad = 1'b0;
		muxA = 2'b00;
		muxB = 2'b00;
		muxC = '0;
		muxD = 1'b0;
		muxF = 2'b00;
		muxH = 1'b0;
		muxJ = 2'b00;
		shiftEnable = 1'b0;
		shiftType = '0;
		offsetShift = 1'b0;
		aluOp = '0;
		case (state)
			// PC to MAR
			`ST_FETCH_ADDR:
			begin
				marLoad = 1'b1;
				muxA = 2'b10;
				muxD = 1'b1;
				aluOp = 5'b10000;
			end
			// PC + 4 while the read starts
			`ST_FETCH_INC:
			begin
				regFileLoad = 1'b1;
				memRead = 1'b1;
				memValid = 1'b1;
				muxA = 2'b10;
				muxC = 3'b001;
				muxD = 1'b1;
				aluOp = 5'b10001;
			end
			`ST_FETCH_WAIT:
			begin
				irLoad = 1'b1;
				memRead = 1'b1;
				memValid = 1'b1;
			end
			`ST_DP_SHIFT:
			begin
				regFileLoad = 1'b1;
				muxB = 2'b01;
				muxC = 3'b100;
				muxD = 1'b1;
				shiftEnable = 1'b1;
				shiftType = 3'b001;
				aluOp = 5'b10011;
			end
			`ST_DP_IMM:
			begin
				regFileLoad = 1'b1;
				flagLoad = 1'b1;
				muxJ = 2'b01;
			end
			`ST_BR_TARGET:
			begin
				regFileLoad = 1'b1;
				flagLoad = 1'b1;
				muxB = 2'b01;
				muxC = 3'b100;
				muxD = 1'b1;
				muxF = 2'b11;
				muxJ = 2'b11;
				shiftEnable = 1'b1;
				shiftType = 3'b100;
				aluOp = 5'b10011;
			end
			// Offset times four added to PC
			`ST_BR_COMMIT:
			begin
				regFileLoad = 1'b1;
				muxA = 2'b10;
				muxC = 3'b011;
				muxD = 1'b1;
				muxJ = 2'b01;
				offsetShift = 1'b1;
				aluOp = 5'b00100;
			end
			`ST_BR_LINK:
			begin
				regFileLoad = 1'b1;
				muxA = 2'b11;
				muxC = 3'b100;
				muxD = 1'b1;
				muxJ = 2'b01;
				offsetShift = 1'b1;
				aluOp = 5'b00100;
			end
			// Reset, decode and unused codes keep the idle word
			default: ;
		endcase
	end

endmodule

/* source/controlUnit.sv */
`timescale 1ns/10ps
`include "cu_consts.svh"

module controlUnit import cuPkg::*;
(
	input logic CLK,
	input logic rst,
	input irWord_t ir,
	input logic [`FLAGS_W-1:0] flags,
	input logic moc,
	output logic regFileLoad,
	output logic irLoad,
	output logic marLoad,
	output logic memRead,
	output logic memValid,
	output logic flagLoad,
	output logic [1:0] muxA,
	output logic [1:0] muxB,
	output logic [`MUXC_W-1:0] muxC,
	output logic muxD,
	output logic [1:0] muxF,
	output logic muxH,
	output logic [1:0] muxJ,
	output logic shiftEnable,
	output logic [`SHIFT_T_W-1:0] shiftType,
	output logic offsetShift,
	output logic [`ALUOP_W-1:0] aluOp
);

	logic [`STATE_W-1:0] state;
	logic [`STATE_W-1:0] execEntry;
	logic condPass;

	stateSequencer stateSequencer_i
	(
		.CLK(CLK),
		.rst(rst),
		.moc(moc),
		.condPass(condPass),
		.execEntry(execEntry),
		.state(state)
	);

	instrDecoder instrDecoder_i
	(
		.ir(ir),
		.execEntry(execEntry)
	);

	condEvaluator condEvaluator_i
	(
		.ir(ir),
		.flags(flags),
		.condPass(condPass)
	);

	controlRom controlRom_i
	(
		.state(state),
		.regFileLoad(regFileLoad),
		.irLoad(irLoad),
		.marLoad(marLoad),
		.memRead(memRead),
		.memValid(memValid),
		.flagLoad(flagLoad),
		.muxA(muxA),
		.muxB(muxB),
		.muxC(muxC),
		.muxD(muxD),
		.muxF(muxF),
		.muxH(muxH),
		.muxJ(muxJ),
		.shiftEnable(shiftEnable),
		.shiftType(shiftType),
		.offsetShift(offsetShift),
		.aluOp(aluOp)
	);

endmodule

/* source/cuPkg.sv */
`include "cu_consts.svh"

package cuPkg;

	// Instruction register word, seen either as data processing or as branch
	// Condition and class sit in the same bits in both views
	typedef union packed
	{
		struct packed
		{
			logic [`COND_W-1:0] cond;
			logic [`CLASS_W-1:0] instrClass;
			logic [3:0] opcode;
			logic setFlags;
			logic [3:0] rn;
			logic [3:0] rd;
			// Shifted register or rotated immediate
			logic [11:0] operand2;
		} dp;
		struct packed
		{
			logic [`COND_W-1:0] cond;
			logic [`CLASS_W-1:0] instrClass;
			logic link;
			// Word offset, sign extended and shifted by the datapath
			logic [23:0] offset;
		} br;
	} irWord_t;

endpackage

/* source/instrDecoder.sv */
`timescale 1ns/10ps
`include "cu_consts.svh"

module instrDecoder import cuPkg::*;
(
	input irWord_t ir,
	output logic [`STATE_W-1:0] execEntry
);

	always_comb
	begin
		case (ir.dp.instrClass)
			`CLASS_DP_SHIFT:
				execEntry = `ST_DP_SHIFT;
			`CLASS_DP_IMM:
				execEntry = `ST_DP_IMM;
			`CLASS_BRANCH:
			begin
				if (ir.br.link)
					execEntry = `ST_BR_LINK;
				else
					execEntry = `ST_BR_TARGET;
			end
			// Loads, stores and the rest are skipped
			default:
				execEntry = `ST_FETCH_ADDR;
		endcase
	end

endmodule

/* source/stateSequencer.sv */
`timescale 1ns/10ps
`include "cu_consts.svh"

module stateSequencer
(
	input logic CLK,
	input logic rst,
	input logic moc,
	input logic condPass,
	input logic [`STATE_W-1:0] execEntry,
	output logic [`STATE_W-1:0] state
);

	logic [`STATE_W-1:0] nextState;

	always_ff @(posedge CLK)
	begin
		if (rst)
			state <= `ST_RESET;
		else
			state <= nextState;
	end

	always_comb
	begin
		case (state)
			`ST_RESET:
				nextState = `ST_FETCH_ADDR;
			`ST_FETCH_ADDR:
				nextState = `ST_FETCH_INC;
			`ST_FETCH_INC:
				nextState = `ST_FETCH_WAIT;
			// Hold until memory reports completion
			`ST_FETCH_WAIT:
			begin
				if (moc)
					nextState = `ST_DECODE;
				else
					nextState = `ST_FETCH_WAIT;
			end
			// Failed condition skips the instruction
			`ST_DECODE:
			begin
				if (condPass)
					nextState = execEntry;
				else
					nextState = `ST_FETCH_ADDR;
			end
			`ST_DP_SHIFT:
				nextState = `ST_FETCH_ADDR;
			`ST_DP_IMM:
				nextState = `ST_FETCH_ADDR;
			// Link saves the return address first, then joins plain branch
			`ST_BR_LINK:
				nextState = `ST_BR_TARGET;
			`ST_BR_TARGET:
				nextState = `ST_BR_COMMIT;
			`ST_BR_COMMIT:
				nextState = `ST_FETCH_ADDR;
			default:
				nextState = `ST_RESET;
		endcase
	end

	stateLegal: assert property
	(
		@(posedge CLK) disable iff (rst)
		state inside {`ST_RESET, `ST_FETCH_ADDR, `ST_FETCH_INC, `ST_FETCH_WAIT,
			`ST_DECODE, `ST_DP_SHIFT, `ST_DP_IMM, `ST_BR_TARGET, `ST_BR_COMMIT,
			`ST_BR_LINK}
	)
	else
		$error("stateSequencer reached undefined state %0d", state);

	// Wait is only left after a sampled moc
	fetchWaitHeld: assert property
	(
		@(posedge CLK)
		(state == `ST_FETCH_WAIT && !moc && !rst) |=> (state == `ST_FETCH_WAIT)
	)
	else
		$error("stateSequencer left fetch wait without moc");

endmodule

/* verif/cuModel.sv */
`timescale 1ns/10ps
`include "cu_consts.svh"

module cuModel
(
	input logic [31:0] instr,
	input logic [`FLAGS_W-1:0] flagsIn,
	input int mocDelay,
	output logic [15:0][31:0] expSeq,
	output int expLen
);

	// Word layout, MSB first: 3 spare bits, regFileLoad irLoad marLoad memRead memValid
	// flagLoad, muxA, muxB, muxC, muxD, muxF, muxH, muxJ, shiftEnable, shiftType,
	// offsetShift, aluOp
	localparam logic [31:0] wordFetchAddr = {3'b000, 6'b001000, 2'b10, 2'b00, 3'b000,
		1'b1, 2'b00, 1'b0, 2'b00, 1'b0, 3'b000, 1'b0, 5'b10000};
	localparam logic [31:0] wordFetchInc = {3'b000, 6'b100110, 2'b10, 2'b00, 3'b001,
		1'b1, 2'b00, 1'b0, 2'b00, 1'b0, 3'b000, 1'b0, 5'b10001};
	localparam logic [31:0] wordFetchWait = {3'b000, 6'b010110, 23'd0};
	localparam logic [31:0] wordDpShift = {3'b000, 6'b100000, 2'b00, 2'b01, 3'b100,
		1'b1, 2'b00, 1'b0, 2'b00, 1'b1, 3'b001, 1'b0, 5'b10011};
	localparam logic [31:0] wordDpImm = {3'b000, 6'b100001, 2'b00, 2'b00, 3'b000,
		1'b0, 2'b00, 1'b0, 2'b01, 1'b0, 3'b000, 1'b0, 5'b00000};
	localparam logic [31:0] wordBrTarget = {3'b000, 6'b100001, 2'b00, 2'b01, 3'b100,
		1'b1, 2'b11, 1'b0, 2'b11, 1'b1, 3'b100, 1'b0, 5'b10011};
	localparam logic [31:0] wordBrCommit = {3'b000, 6'b100000, 2'b10, 2'b00, 3'b011,
		1'b1, 2'b00, 1'b0, 2'b01, 1'b0, 3'b000, 1'b1, 5'b00100};
	localparam logic [31:0] wordBrLink = {3'b000, 6'b100000, 2'b11, 2'b00, 3'b100,
		1'b1, 2'b00, 1'b0, 2'b01, 1'b0, 3'b000, 1'b1, 5'b00100};

	logic nFlag;
	logic zFlag;
	logic cFlag;
	logic vFlag;
	logic baseCond;
	logic condOk;

	assign {nFlag, zFlag, cFlag, vFlag} = flagsIn;

	// Even codes give the base test, odd codes invert it
	always_comb
	begin
		case (instr[31:29])
			3'd0: baseCond = zFlag;
			3'd1: baseCond = cFlag;
			3'd2: baseCond = nFlag;
			3'd3: baseCond = vFlag;
			3'd4: baseCond = cFlag && !zFlag;
			3'd5: baseCond = (nFlag == vFlag);
			3'd6: baseCond = !zFlag && (nFlag == vFlag);
			default: baseCond = 1'b1;
		endcase
		if (instr[31:28] == 4'b1111)
			condOk = 1'b0;
		else
			condOk = baseCond ^ instr[28];
	end

	always_comb
	begin
		logic [3:0] k;
		k = 4'd0;
		expSeq = '0;
		expSeq[k] = wordFetchAddr;
		k = k + 4'd1;
		expSeq[k] = wordFetchInc;
		k = k + 4'd1;
		for (int w = 0; w < 8; w++)
		begin
			if (w <= mocDelay)
			begin
				expSeq[k] = wordFetchWait;
				k = k + 4'd1;
			end
		end
		// Decode cycle is all zero
		k = k + 4'd1;
		if (condOk)
		begin
			if (instr[27:25] == `CLASS_DP_SHIFT)
			begin
				expSeq[k] = wordDpShift;
				k = k + 4'd1;
			end
			else if (instr[27:25] == `CLASS_DP_IMM)
			begin
				expSeq[k] = wordDpImm;
				k = k + 4'd1;
			end
			else if (instr[27:25] == `CLASS_BRANCH)
			begin
				if (instr[24])
				begin
					expSeq[k] = wordBrLink;
					k = k + 4'd1;
				end
				expSeq[k] = wordBrTarget;
				k = k + 4'd1;
				expSeq[k] = wordBrCommit;
				k = k + 4'd1;
			end
		end
		// Next fetch
		expSeq[k] = wordFetchAddr;
		k = k + 4'd1;
		expLen = {28'd0, k};
	end

endmodule

/* verif/tbControlUnit.sv */
`timescale 1ns/10ps
`include "cu_consts.svh"

module tbControlUnit import cuPkg::*;
();

	localparam int waitLimit = 20;

	logic CLK = 1'b0;
	logic rst;
	irWord_t ir;
	logic [`FLAGS_W-1:0] flags;
	logic moc = 1'b0;
	logic regFileLoad;
	logic irLoad;
	logic marLoad;
	logic memRead;
	logic memValid;
	logic flagLoad;
	logic [1:0] muxA;
	logic [1:0] muxB;
	logic [`MUXC_W-1:0] muxC;
	logic muxD;
	logic [1:0] muxF;
	logic muxH;
	logic [1:0] muxJ;
	logic shiftEnable;
	logic [`SHIFT_T_W-1:0] shiftType;
	logic offsetShift;
	logic [`ALUOP_W-1:0] aluOp;
	logic [31:0] ctrlWord;

	int mocDelay;
	int waitCnt;
	logic [31:0] modelInstr;
	logic [`FLAGS_W-1:0] modelFlags;
	int modelDelay;
	logic [15:0][31:0] expSeq;
	int expLen;
	logic [31:0] rngState;
	int testsRun;
	int testsFailed;

	always #50 CLK = ~CLK;

	controlUnit controlUnit_i
	(
		.CLK(CLK),
		.rst(rst),
		.ir(ir),
		.flags(flags),
		.moc(moc),
		.regFileLoad(regFileLoad),
		.irLoad(irLoad),
		.marLoad(marLoad),
		.memRead(memRead),
		.memValid(memValid),
		.flagLoad(flagLoad),
		.muxA(muxA),
		.muxB(muxB),
		.muxC(muxC),
		.muxD(muxD),
		.muxF(muxF),
		.muxH(muxH),
		.muxJ(muxJ),
		.shiftEnable(shiftEnable),
		.shiftType(shiftType),
		.offsetShift(offsetShift),
		.aluOp(aluOp)
	);

	cuModel cuModel_i
	(
		.instr(modelInstr),
		.flagsIn(modelFlags),
		.mocDelay(modelDelay),
		.expSeq(expSeq),
		.expLen(expLen)
	);

	assign ctrlWord = {3'b000, regFileLoad, irLoad, marLoad, memRead, memValid, flagLoad,
		muxA, muxB, muxC, muxD, muxF, muxH, muxJ, shiftEnable, shiftType, offsetShift, aluOp};

	// Memory answers mocDelay cycles into the wait
	always @(posedge CLK)
	begin
		if (rst)
		begin
			moc <= 1'b0;
			waitCnt <= 0;
		end
		else if (memValid && !irLoad)
		begin
			waitCnt <= 1;
			moc <= (mocDelay == 0);
		end
		else if (irLoad && !moc)
		begin
			waitCnt <= waitCnt + 1;
			moc <= (waitCnt == mocDelay);
		end
		else
			moc <= 1'b0;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic checkWord(input string name, input int cycle, input logic [31:0] exp,
		inout int errs);
		if (ctrlWord != exp)
		begin
			$display("Fail %s cycle %0d expected 0x%08h actual 0x%08h", name, cycle, exp,
				ctrlWord);
			errs++;
		end
	endtask

	task automatic reportTest(input string name, input int errs);
		testsRun++;
		if (errs == 0)
			$display("%s passed", name);
		else
		begin
			$display("%s failed with %0d errors", name, errs);
			testsFailed++;
		end
	endtask

	// Runs one instruction from its fetch address cycle to the next fetch address cycle
	task automatic runInstr(input string name, input logic [31:0] instr,
		input logic [`FLAGS_W-1:0] flg, input int delay, inout int errs);
		int cnt;
		cnt = 0;
		modelInstr = instr;
		modelFlags = flg;
		modelDelay = delay;
		while (!marLoad && cnt < waitLimit)
		begin
			@(negedge CLK);
			cnt++;
		end
		if (!marLoad)
		begin
			$display("%s timed out waiting for the fetch address cycle", name);
			errs++;
		end
		else
		begin
			// First word is the same for every instruction
			checkWord(name, 0, expSeq[0], errs);
			@(posedge CLK);
			ir <= instr;
			flags <= flg;
			mocDelay <= delay;
			for (int i = 1; i < expLen; i++)
			begin
				@(negedge CLK);
				checkWord(name, i, expSeq[i[3:0]], errs);
			end
		end
	endtask

	task automatic resetTest();
		int errs;
		errs = 0;
		rst <= 1'b1;
		repeat (2) @(posedge CLK);
		rst <= 1'b0;
		@(negedge CLK);
		checkWord("reset", 0, 32'd0, errs);
		@(negedge CLK);
		checkWord("reset", 1, expSeq[0], errs);
		reportTest("reset", errs);
	endtask

	task automatic mocWaitTest();
		int errs;
		errs = 0;
		runInstr("mocWait", {`COND_AL, `CLASS_DP_IMM, 25'h0a5a5a5}, 4'b0000, 3, errs);
		runInstr("mocWait", {`COND_AL, `CLASS_DP_IMM, 25'h1000001}, 4'b0000, 0, errs);
		reportTest("mocWait", errs);
	endtask

	task automatic condFailTest();
		int errs;
		errs = 0;
		runInstr("condFail", {`COND_EQ, `CLASS_DP_SHIFT, 25'h0012345}, 4'b1011, 1, errs);
		runInstr("condFail", {`COND_NE, `CLASS_BRANCH, 25'h1000020}, 4'b0100, 0, errs);
		reportTest("condFail", errs);
	endtask

	task automatic dataProcTest();
		int errs;
		errs = 0;
		runInstr("dpShift", {`COND_AL, `CLASS_DP_SHIFT, 25'h0321003}, 4'b0000, 1, errs);
		runInstr("dpImm", {`COND_AL, `CLASS_DP_IMM, 25'h05430ff}, 4'b0000, 2, errs);
		reportTest("dataProc", errs);
	endtask

	task automatic branchTest();
		int errs;
		errs = 0;
		runInstr("branch", {`COND_AL, `CLASS_BRANCH, 1'b0, 24'h000040}, 4'b0000, 0, errs);
		runInstr("branchLink", {`COND_AL, `CLASS_BRANCH, 1'b1, 24'hfffff0}, 4'b0000, 1, errs);
		reportTest("branch", errs);
	endtask

	task automatic randomTest();
		logic [31:0] r;
		logic [2:0] cls;
		int errs;
		errs = 0;
		for (int n = 0; n < 40; n++)
		begin
			r = xorshift(rngState);
			rngState = r;
			// Bias toward the supported classes
			case (r[9:8])
				2'd0: cls = `CLASS_DP_SHIFT;
				2'd1: cls = `CLASS_DP_IMM;
				2'd2: cls = `CLASS_BRANCH;
				default: cls = r[27:25];
			endcase
			rngState = xorshift(rngState);
			runInstr("random", {r[31:28], cls, r[24:0]}, rngState[3:0],
				{30'd0, rngState[5:4]}, errs);
		end
		reportTest("random", errs);
	endtask

	initial
	begin
		rst = 1'b1;
		ir = '0;
		flags = '0;
		mocDelay = 0;
		modelInstr = '0;
		modelFlags = '0;
		modelDelay = 0;
		rngState = 32'd53;
		testsRun = 0;
		testsFailed = 0;
		resetTest();
		mocWaitTest();
		condFailTest();
		dataProcTest();
		branchTest();
		randomTest();
		$display("Tests run %0d, tests failed %0d", testsRun, testsFailed);
		if (testsFailed == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
